/* rtl/Alignment.sv */
// Stage 2 of the adder pipeline, aligns the smaller significand to the larger exponent
`timescale 1ns/1ps

module Alignment
    import fpAddPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     unpackValid,
    input  exponentT exponentA,
    input  exponentT exponentB,
    input  mantissaT mantissaA,
    input  mantissaT mantissaB,
    input  logic     signA,
    input  logic     signB,
    input  logic     effSubtract,
    input  logic     specialValid,
    input  floatT    specialResult,
    output logic     alignValid,
    output alignedT  alignedMantissaA,
    output alignedT  alignedMantissaB,
    output exponentT exponentOut,
    output logic     guardBit,
    output logic     roundBit,
    output logic     stickyBit,
    output logic     alignSignA,
    output logic     alignSignB,
    output logic     alignEffSubtract,
    output logic     alignSpecialValid,
    output floatT    alignSpecialResult
);

    logic [EXT_WIDTH-1:0] extendedA, extendedB;             // Implicit one, fraction, two low bits
    logic [EXT_WIDTH-1:0] toShift;                          // Operand with the smaller exponent
    logic [EXT_WIDTH-1:0] shifted;
    exponentT             largerExp;
    exponentT             expDifferential;
    logic                 shiftA;                           // High when a is the one shifted
    logic                 lostBits;
    alignedT              nextA, nextB;

    always_comb
    begin
        // Zero exponent means a zero operand, so no implicit one
        extendedA = {exponentA != '0, mantissaA, 2'b00};
        extendedB = {exponentB != '0, mantissaB, 2'b00};

        if (exponentA >= exponentB)
        begin
            shiftA          = 1'b0;
            largerExp       = exponentA;
            expDifferential = exponentA - exponentB;
            toShift         = extendedB;
        end
        else
        begin
            shiftA          = 1'b1;
            largerExp       = exponentB;
            expDifferential = exponentB - exponentA;
            toShift         = extendedA;
        end

        shifted = toShift >> expDifferential;

        if (expDifferential > SHIFT_LIMIT)
            lostBits = |toShift;                            // Everything went past round
        else
            lostBits = |(toShift & ~({EXT_WIDTH{1'b1}} << expDifferential));

        nextA = shiftA ? shifted[EXT_WIDTH-1:2] : extendedA[EXT_WIDTH-1:2];
        nextB = shiftA ? extendedB[EXT_WIDTH-1:2] : shifted[EXT_WIDTH-1:2];
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            alignValid <= 1'b0;
        else
            alignValid <= unpackValid;
    end

    always_ff @(posedge clk)
    begin
        alignedMantissaA   <= nextA;
        alignedMantissaB   <= nextB;
        exponentOut        <= largerExp;
        guardBit           <= shifted[1];
        roundBit           <= shifted[0];
        stickyBit          <= lostBits;
        alignSignA         <= signA;
        alignSignB         <= signB;
        alignEffSubtract   <= effSubtract;
        alignSpecialValid  <= specialValid;
        alignSpecialResult <= specialResult;
    end

    // Equal exponents need no shift, so no low bits appear next cycle
    assert property (@(posedge clk) disable iff (!rstN)
        (unpackValid && (exponentA == exponentB)) |=> !(guardBit || roundBit || stickyBit))
    else
        $error("Low bits set after aligning equal exponents");

endmodule

/* rtl/fpAddPkg.sv */
// Shared widths, field positions, types and constants for the pipelined single-precision adder
package fpAddPkg;

    // Field widths of an IEEE-754 single-precision word
    localparam int FLOAT_WIDTH = 32;
    localparam int EXP_WIDTH   = 8;
    localparam int MAN_WIDTH   = 23;

    // Bit positions inside the packed word
    localparam int SIGN_POS = 31;
    localparam int EXP_MSB  = 30;
    localparam int EXP_LSB  = 23;
    localparam int MAN_MSB  = 22;

    // Significand with implicit one plus guard and round positions
    localparam int EXT_WIDTH = MAN_WIDTH + 3;

    typedef logic [FLOAT_WIDTH-1:0] floatT;                 // Packed single-precision word
    typedef logic [EXP_WIDTH-1:0]   exponentT;              // Biased exponent
    typedef logic [MAN_WIDTH-1:0]   mantissaT;              // Stored fraction
    typedef logic [MAN_WIDTH:0]     alignedT;               // Significand with implicit bit
    typedef logic [MAN_WIDTH+1:0]   sumT;                   // Significand sum with carry

    localparam exponentT EXP_MAX = 8'hFF;                   // Infinity and NaN exponent
    localparam floatT    QNAN    = 32'h7FC0_0000;           // Canonical quiet NaN

    // Right shifts larger than this leave nothing but sticky
    localparam int SHIFT_LIMIT = 26;

endpackage

/* rtl/fpAdder.sv */
// Top of the four-stage single-precision adder, result follows inValid by four cycles
`timescale 1ns/1ps

module fpAdder
    import fpAddPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  inValid,
    input  floatT a,
    input  floatT b,
    input  logic  subtract,
    output logic  outValid,
    output floatT result
);

    // Stage 1 outputs
    logic     unpackValid, signA, signB, effSubtract;
    exponentT exponentA, exponentB;
    mantissaT mantissaA, mantissaB;
    logic     unpackSpecialValid;
    floatT    unpackSpecialResult;

    // Stage 2 outputs
    logic     alignValid, guardBit, roundBit, stickyBit;
    alignedT  alignedMantissaA, alignedMantissaB;
    exponentT exponentOut;
    logic     alignSignA, alignSignB, alignEffSubtract;
    logic     alignSpecialValid;
    floatT    alignSpecialResult;

    // Stage 3 outputs
    logic     sumValid, sumGuard, sumRound, sumSticky, sumSign;
    sumT      sum;
    exponentT sumExponent;
    logic     sumSpecialValid;
    floatT    sumSpecialResult;

    operandUnpack unpackStage (
        .clk(clk), .rstN(rstN), .inValid(inValid), .a(a), .b(b), .subtract(subtract),
        .unpackValid(unpackValid), .signA(signA), .signB(signB),
        .exponentA(exponentA), .exponentB(exponentB),
        .mantissaA(mantissaA), .mantissaB(mantissaB), .effSubtract(effSubtract),
        .specialValid(unpackSpecialValid), .specialResult(unpackSpecialResult)
    );

    Alignment alignStage (
        .clk(clk), .rstN(rstN), .unpackValid(unpackValid),
        .exponentA(exponentA), .exponentB(exponentB),
        .mantissaA(mantissaA), .mantissaB(mantissaB),
        .signA(signA), .signB(signB), .effSubtract(effSubtract),
        .specialValid(unpackSpecialValid), .specialResult(unpackSpecialResult),
        .alignValid(alignValid),
        .alignedMantissaA(alignedMantissaA), .alignedMantissaB(alignedMantissaB),
        .exponentOut(exponentOut),
        .guardBit(guardBit), .roundBit(roundBit), .stickyBit(stickyBit),
        .alignSignA(alignSignA), .alignSignB(alignSignB), .alignEffSubtract(alignEffSubtract),
        .alignSpecialValid(alignSpecialValid), .alignSpecialResult(alignSpecialResult)
    );

    significandAdder addStage (
        .clk(clk), .rstN(rstN), .alignValid(alignValid),
        .alignedMantissaA(alignedMantissaA), .alignedMantissaB(alignedMantissaB),
        .exponentOut(exponentOut),
        .guardBit(guardBit), .roundBit(roundBit), .stickyBit(stickyBit),
        .alignSignA(alignSignA), .alignSignB(alignSignB), .alignEffSubtract(alignEffSubtract),
        .alignSpecialValid(alignSpecialValid), .alignSpecialResult(alignSpecialResult),
        .sumValid(sumValid), .sum(sum),
        .sumGuard(sumGuard), .sumRound(sumRound), .sumSticky(sumSticky),
        .sumSign(sumSign), .sumExponent(sumExponent),
        .specialValid(sumSpecialValid), .specialResult(sumSpecialResult)
    );

    normalizeRound roundStage (
        .clk(clk), .rstN(rstN), .sumValid(sumValid), .sum(sum),
        .sumGuard(sumGuard), .sumRound(sumRound), .sumSticky(sumSticky),
        .sumSign(sumSign), .sumExponent(sumExponent),
        .specialValid(sumSpecialValid), .specialResult(sumSpecialResult),
        .outValid(outValid), .result(result)
    );

endmodule

/* rtl/normalizeRound.sv */
// Stage 4 of the adder pipeline, normalizes, rounds to nearest-even and packs the result
`timescale 1ns/1ps

module normalizeRound
    import fpAddPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     sumValid,
    input  sumT      sum,
    input  logic     sumGuard,
    input  logic     sumRound,
    input  logic     sumSticky,
    input  logic     sumSign,
    input  exponentT sumExponent,
    input  logic     specialValid,
    input  floatT    specialResult,
    output logic     outValid,
    output floatT    result
);

    logic [4:0]                   leadZeros;
    logic [MAN_WIDTH+2:0]         shiftField;               // Sum body with guard and round below
    alignedT                      normMant;
    logic                         normGuard, normRound, normSticky;
    logic                         roundUp;
    logic signed [EXP_WIDTH+1:0]  normExp;                  // Two spare bits catch under and overflow
    logic signed [EXP_WIDTH+1:0]  finalExp;
    logic [MAN_WIDTH+1:0]         rounded;
    logic                         isZero;
    floatT                        nextResult;

    always_comb
    begin
        leadZeros = 5'(MAN_WIDTH + 1);
        for (int i = 0; i <= MAN_WIDTH; i++)
        begin
            if (sum[i])
                leadZeros = 5'(MAN_WIDTH - i);              // Highest set bit wins
        end

        shiftField = {sum[MAN_WIDTH:0], sumGuard, sumRound} << leadZeros;

        if (sum[MAN_WIDTH+1])
        begin
            // Carry out, so shift right once
            normMant   = sum[MAN_WIDTH+1:1];
            normGuard  = sum[0];
            normRound  = sumGuard;
            normSticky = sumRound | sumSticky;
            normExp    = $signed({2'b00, sumExponent}) + 10'sd1;
        end
        else
        begin
            normMant   = shiftField[MAN_WIDTH+2:2];
            normGuard  = shiftField[1];
            normRound  = shiftField[0];
            normSticky = sumSticky;
            normExp    = $signed({2'b00, sumExponent}) - $signed({5'b00000, leadZeros});
        end

        roundUp  = normGuard & (normRound | normSticky | normMant[0]);  // Ties go to even
        rounded  = {1'b0, normMant} + roundUp;
        finalExp = normExp + $signed({9'b0, rounded[MAN_WIDTH+1]});  // Rounding overflow

        isZero = (sum == '0) && !sumGuard && !sumRound && !sumSticky;

        if (specialValid)
            nextResult = specialResult;
        else if (isZero)
            nextResult = {sumSign, 31'b0};
        else if (normExp <= 0)
            nextResult = {sumSign, 31'b0};                  // Tiny result flushed
        else if (finalExp >= $signed({2'b00, EXP_MAX}))
            nextResult = {sumSign, EXP_MAX, mantissaT'(0)};
        else
            // A rounding carry leaves the low bits all zero
            nextResult = {sumSign, finalExp[EXP_WIDTH-1:0], rounded[MAN_WIDTH-1:0]};
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= sumValid;
            if (sumValid)
                result <= nextResult;                       // Hold last result between pairs
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !$isunknown(outValid))
    else
        $error("outValid is unknown");

endmodule

/* rtl/operandUnpack.sv */
// Stage 1 of the adder pipeline, splits operands into fields and resolves special operands
`timescale 1ns/1ps

module operandUnpack
    import fpAddPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     inValid,
    input  floatT    a,
    input  floatT    b,
    input  logic     subtract,
    output logic     unpackValid,
    output logic     signA,
    output logic     signB,
    output exponentT exponentA,
    output exponentT exponentB,
    output mantissaT mantissaA,
    output mantissaT mantissaB,
    output logic     effSubtract,
    output logic     specialValid,
    output floatT    specialResult
);

    exponentT expA, expB;
    mantissaT fracA, fracB;
    logic     flipSignB;                                    // Sign of b after the operation
    logic     nanA, nanB, infA, infB;
    floatT    nextSpecial;

    always_comb
    begin
        expA      = a[EXP_MSB:EXP_LSB];
        expB      = b[EXP_MSB:EXP_LSB];
        flipSignB = b[SIGN_POS] ^ subtract;                 // a - b becomes a + (-b)

        nanA = (expA == EXP_MAX) && (a[MAN_MSB:0] != '0);
        nanB = (expB == EXP_MAX) && (b[MAN_MSB:0] != '0);
        infA = (expA == EXP_MAX) && (a[MAN_MSB:0] == '0);
        infB = (expB == EXP_MAX) && (b[MAN_MSB:0] == '0);

        // Subnormals are flushed, their exponent is already zero
        fracA = (expA == '0) ? '0 : a[MAN_MSB:0];
        fracB = (expB == '0) ? '0 : b[MAN_MSB:0];

        if (nanA || nanB || (infA && infB && (a[SIGN_POS] != flipSignB)))
            nextSpecial = QNAN;                             // NaN in or inf minus inf
        else if (infA)
            nextSpecial = {a[SIGN_POS], EXP_MAX, mantissaT'(0)};
        else
            nextSpecial = {flipSignB, EXP_MAX, mantissaT'(0)};
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            unpackValid <= 1'b0;
        else
            unpackValid <= inValid;
    end

    always_ff @(posedge clk)
    begin
        signA         <= a[SIGN_POS];
        signB         <= flipSignB;
        exponentA     <= expA;
        exponentB     <= expB;
        mantissaA     <= fracA;
        mantissaB     <= fracB;
        effSubtract   <= a[SIGN_POS] ^ flipSignB;           // Opposite signs subtract
        specialValid  <= (expA == EXP_MAX) || (expB == EXP_MAX);
        specialResult <= nextSpecial;
    end

endmodule

/* rtl/significandAdder.sv */
// Stage 3 of the adder pipeline that adds or subtracts the aligned significands
`timescale 1ns/1ps

module significandAdder
    import fpAddPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     alignValid,
    input  alignedT  alignedMantissaA,
    input  alignedT  alignedMantissaB,
    input  exponentT exponentOut,
    input  logic     guardBit,
    input  logic     roundBit,
    input  logic     stickyBit,
    input  logic     alignSignA,
    input  logic     alignSignB,
    input  logic     alignEffSubtract,
    input  logic     alignSpecialValid,
    input  floatT    alignSpecialResult,
    output logic     sumValid,
    output sumT      sum,
    output logic     sumGuard,
    output logic     sumRound,
    output logic     sumSticky,
    output logic     sumSign,
    output exponentT sumExponent,
    output logic     specialValid,
    output floatT    specialResult
);

    logic                 lowOnA;                           // Low bits belong to a
    logic [2:0]           lowBits;
    logic [MAN_WIDTH+3:0] operandA, operandB;               // Significand with guard, round, sticky
    logic [MAN_WIDTH+4:0] total;
    logic                 nextSign;

    always_comb
    begin
        // The shifted operand lost its leading one and the other kept it
        lowOnA   = !alignedMantissaA[MAN_WIDTH];
        lowBits  = {guardBit, roundBit, stickyBit};
        operandA = {alignedMantissaA, lowOnA ? lowBits : 3'b000};
        operandB = {alignedMantissaB, lowOnA ? 3'b000 : lowBits};

        if (!alignEffSubtract)
        begin
            total    = {1'b0, operandA} + {1'b0, operandB};
            nextSign = alignSignA;                          // Same sign on both
        end
        else if (operandA >= operandB)
        begin
            total    = {1'b0, operandA} - {1'b0, operandB};
            nextSign = (operandA == operandB) ? 1'b0 : alignSignA;  // Exact cancel is +0
        end
        else
        begin
            total    = {1'b0, operandB} - {1'b0, operandA};
            nextSign = alignSignB;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            sumValid <= 1'b0;
        else
            sumValid <= alignValid;
    end

    always_ff @(posedge clk)
    begin
        sum           <= total[MAN_WIDTH+4:3];
        sumGuard      <= total[2];
        sumRound      <= total[1];
        sumSticky     <= total[0];
        sumSign       <= nextSign;
        sumExponent   <= exponentOut;
        specialValid  <= alignSpecialValid;
        specialResult <= alignSpecialResult;
    end

    // Larger minus smaller magnitude can never carry out
    assert property (@(posedge clk) disable iff (!rstN)
        (alignValid && alignEffSubtract) |=> !sum[MAN_WIDTH+1])
    else
        $error("Carry out of the subtraction path");

endmodule

/* tb.f */
+incdir+test
rtl/fpAddPkg.sv
rtl/operandUnpack.sv
rtl/Alignment.sv
rtl/significandAdder.sv
rtl/normalizeRound.sv
rtl/fpAdder.sv
test/fpAdderTb.sv

/* test/fpAddModel.svh */
// Reference model for the adder testbench, included inside the testbench module
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

localparam int WIDE = 288;                                  // Holds any significand at its true weight

// Expected value of a plus b, with b negated when subtract is set
function automatic floatT modelSum(input floatT a, input floatT b, input logic subtract);
    logic            signA, signB, sign;
    int              expA, expB, top, newExp;
    logic [WIDE-1:0] bigA, bigB, mag, rest, half;
    logic [24:0]     mant;

    signA = a[31];
    signB = b[31] ^ subtract;
    expA  = a[30:23];
    expB  = b[30:23];

    if ((expA == 255) || (expB == 255))
    begin
        if (((expA == 255) && (a[22:0] != 0)) || ((expB == 255) && (b[22:0] != 0)))
            return 32'h7FC0_0000;                           // Any NaN gives the quiet NaN
        if ((expA == 255) && (expB == 255) && (signA != signB))
            return 32'h7FC0_0000;                           // Opposite infinities
        return (expA == 255) ? {signA, 8'hFF, 23'h0} : {signB, 8'hFF, 23'h0};
    end

    // Each operand is big times 2^-150, subnormals count as zero
    bigA = (expA == 0) ? '0 : (WIDE'({1'b1, a[22:0]}) << expA);
    bigB = (expB == 0) ? '0 : (WIDE'({1'b1, b[22:0]}) << expB);

    if (signA == signB)
    begin
        mag  = bigA + bigB;
        sign = signA;
    end
    else if (bigA >= bigB)
    begin
        mag  = bigA - bigB;
        sign = (bigA == bigB) ? 1'b0 : signA;               // Exact cancel is +0
    end
    else
    begin
        mag  = bigB - bigA;
        sign = signB;
    end

    if (mag == '0)
        return {sign, 31'h0};

    top = 0;
    for (int i = 0; i < WIDE; i++)
    begin
        if (mag[i])
            top = i;
    end
    newExp = top - 23;                                      // Also the number of bits below the kept 24
    if (newExp <= 0)
        return {sign, 31'h0};                               // Too small for a normal number

    mant = 25'(mag >> newExp);
    rest = mag & ((WIDE'(1) << newExp) - 1);
    half = WIDE'(1) << (newExp - 1);
    if ((rest > half) || ((rest == half) && mant[0]))
        mant = mant + 1;                                    // Nearest, ties to even
    if (mant[24])
    begin
        mant   = mant >> 1;
        newExp = newExp + 1;
    end

    if (newExp >= 255)
        return {sign, 8'hFF, 23'h0};
    return {sign, 8'(newExp), mant[22:0]};
endfunction

`endif

/* test/fpAdderTb.sv */
// Testbench for the pipelined single-precision adder that runs a case table and random pairs
`timescale 1ns/1ps

module fpAdderTb;
    import fpAddPkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_PAIRS = 300;
    localparam int LATENCY      = 4;                        // Drive edge to outValid edge

    typedef struct packed
    {
        floatT a;
        floatT b;
        logic  subtract;
        floatT expected;
    } rowT;

    logic   clk, rstN, inValid, subtract, outValid;
    floatT  a, b, result;

    rowT    stimTable [$];
    floatT  expectResult [$];
    longint expectTime [$];                                 // Negedge at which each result is due
    longint timeLimit = 0;

    `include "fpAddModel.svh"

    fpAdder UUT (
        .clk(clk), .rstN(rstN), .inValid(inValid), .a(a), .b(b), .subtract(subtract),
        .outValid(outValid), .result(result)
    );

    task automatic stopOnFailure();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected)
        begin
            $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic addRow(input floatT opA, input floatT opB, input logic sub, input floatT sum);
        stimTable.push_back({opA, opB, sub, sum});
    endtask

    task automatic loadTable();
        addRow(32'h3F800000, 32'h3F800000, 1'b0, 32'h40000000);  // 1 + 1
        addRow(32'h3F800000, 32'h40000000, 1'b0, 32'h40400000);  // Unequal exponents
        addRow(32'h40400000, 32'h3F800000, 1'b1, 32'h40000000);  // 3 - 1
        addRow(32'h3FC00000, 32'h40400000, 1'b1, 32'hBFC00000);  // Result takes sign of b
        addRow(32'h3F800000, 32'h30800000, 1'b0, 32'h3F800000);  // Shift of 30 leaves only sticky
        addRow(32'h3F800000, 32'h30800000, 1'b1, 32'h3F800000);  // Sticky borrow rounds back
        addRow(32'h3F800000, 32'h33800000, 1'b0, 32'h3F800000);  // Tie with even last bit stays
        addRow(32'h3F800001, 32'h33800000, 1'b0, 32'h3F800002);  // Tie with odd last bit rounds up
        addRow(32'h3FFFFFFF, 32'h33800000, 1'b0, 32'h40000000);  // Rounding carry
        addRow(32'h3F800000, 32'hBF800000, 1'b0, 32'h00000000);  // Exact cancel
        addRow(32'hBF800000, 32'hBF800000, 1'b1, 32'h00000000);  // -1 - -1 is +0
        addRow(32'h3F800000, 32'h3F7FFFFF, 1'b1, 32'h33800000);  // Shift left by 24
        addRow(32'h3FC00000, 32'h3F800000, 1'b1, 32'h3F000000);
        addRow(32'h3F800000, 32'h00000001, 1'b0, 32'h3F800000);  // Subnormal flushed
        addRow(32'h80400000, 32'h80000001, 1'b0, 32'h80000000);  // Two subnormals give -0
        addRow(32'h00800000, 32'h00C00000, 1'b1, 32'h80000000);  // Tiny result flushed
        addRow(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, 32'h7F800000);  // Overflow
        addRow(32'h7F7FFFFF, 32'h73000000, 1'b0, 32'h7F800000);  // Overflow by rounding
        addRow(32'h7F800000, 32'h3F800000, 1'b0, 32'h7F800000);  // inf + 1
        addRow(32'h3F800000, 32'h7F800000, 1'b1, 32'hFF800000);  // 1 - inf
        addRow(32'h7F800000, 32'h7F800000, 1'b1, 32'h7FC00000);  // inf - inf
        addRow(32'h7FC12345, 32'h3F800000, 1'b0, 32'h7FC00000);  // NaN in
        addRow(32'hFF800000, 32'hFF800000, 1'b0, 32'hFF800000);
    endtask

    // Random operand whose exponent lies within three steps of base
    function automatic floatT nearOperand(input floatT base);
        logic [7:0] e;
        e = base[30:23] + 8'($urandom % 7) - 8'd3;
        return {1'($urandom), e, 23'($urandom)};
    endfunction

    task automatic applyPair(input floatT opA, input floatT opB, input logic sub,
                             input floatT expected);
        @(posedge clk);
        inValid  <= 1'b1;
        a        <= opA;
        b        <= opB;
        subtract <= sub;
        expectResult.push_back(expected);
        expectTime.push_back($time + LATENCY * CLK_PERIOD + CLK_PERIOD / 2);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin : mainSequence
        rowT   row;
        floatT randA, randB;
        logic  randSub;

        void'($urandom(19));
        rstN     = 1'b0;
        inValid  = 1'b0;
        a        = '0;
        b        = '0;
        subtract = 1'b0;
        loadTable();
        timeLimit = (stimTable.size() + RANDOM_PAIRS + RESET_CYCLES + 20) * CLK_PERIOD;

        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue(outValid, 1'b0, "outValid after reset");
        checkValue(result, '0, "result after reset");

        foreach (stimTable[i])
        begin
            row = stimTable[i];
            checkValue(modelSum(row.a, row.b, row.subtract), row.expected,
                       $sformatf("model for table row %0d", i));
            applyPair(row.a, row.b, row.subtract, row.expected);
        end

        repeat (RANDOM_PAIRS)
        begin
            randA   = $urandom;
            randB   = ($urandom % 4 == 0) ? floatT'($urandom) : nearOperand(randA);
            randSub = 1'($urandom);
            applyPair(randA, randB, randSub, modelSum(randA, randB, randSub));
        end

        @(posedge clk);
        inValid <= 1'b0;
        wait (expectResult.size() == 0);
        repeat (2) @(posedge clk);

        $display("TESTS PASSED");
        $finish;
    end

    // Outputs are sampled on the falling edge away from the drive edge
    always @(negedge clk)
    begin
        if (rstN && (outValid !== 1'b0))
        begin
            if (expectResult.size() == 0)
            begin
                $display("outValid went high at %0d ns with no pair in flight", $time);
                stopOnFailure();
            end
            else
            begin
                checkValue($time, expectTime.pop_front(), "arrival time");
                checkValue(result, expectResult.pop_front(), "result");
            end
        end
    end

    initial
    begin : watchdog
        wait (timeLimit != 0);
        #(timeLimit);
        $display("Timeout, the run did not finish within %0d ns", timeLimit);
        stopOnFailure();
    end

endmodule
